//--- sim.f
uart_bus_pkg.sv
uart_regs_pkg.sv
sync_fifo.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
tb_clk_gen.sv
tb_uart_assertions.sv
tb_uart.sv

//--- Bender.yml
package:
  name: wb_uart

sources:
  - uart_bus_pkg.sv
  - uart_regs_pkg.sv
  - sync_fifo.sv
  - uart_baud_gen.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_regs.sv
  - uart_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_uart_assertions.sv
      - tb_uart.sv

//--- tb_uart.sv
// top testbench of the wishbone uart, runs reset, transmit, receive, overflow and loopback tests.
`timescale 1ns/1ps

module tb_uart;

	import uart_bus_pkg::*;
	import uart_regs_pkg::*;

	localparam int TX_DEPTH    = 4;
	localparam int RX_DEPTH    = 4;
	localparam int ACK_LIMIT   = 16;    // clocks allowed for an acknowledge.
	localparam int START_LIMIT = 2000;  // clocks allowed before a start bit shows up.
	localparam int POLL_LIMIT  = 400;   // status reads allowed while waiting for a level.

	logic        clk, rst_n;
	wb_req_t     req;
	wb_rsp_t     rsp;
	logic        txd, rxd, rxd_drv, loop_en;
	logic [31:0] seed;
	int          errors, checks, timeouts, div_val;
	logic [7:0]  burst[$];     // bytes the decoder should see, in order.
	logic [7:0]  written[$];   // every byte written to txdata, kept or not.
	logic [7:0]  rx_model[$];  // expected contents of the receive fifo.
	logic [7:0]  tx_model[$];  // expected contents of the transmit fifo.

	tb_clk_gen #(.PERIOD(8), .RST_CYCLES(5)) clk_gen (.clk, .rst_n);

	uart_top #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) uut (
		.clk, .rst_n, .wb_req(req), .wb_rsp(rsp), .txd, .rxd
	);

	assign rxd = loop_en ? txd : rxd_drv;  // loopback joins the line to itself.

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] rand_byte();
		seed = lcg_next(seed);
		return seed[31:24];  // the top bits of an lcg are the most random.
	endfunction

	// status word as the register map defines it for the given fifo levels.
	function automatic uart_status_t expected_status(input int tx_n, input int rx_n);
		uart_status_t s;
		s          = '0;
		s.rx_level = 8'(rx_n);
		s.tx_level = 8'(tx_n);
		s.rx_full  = (rx_n == RX_DEPTH);
		s.rx_empty = (rx_n == 0);
		s.tx_full  = (tx_n == TX_DEPTH);
		s.tx_empty = (tx_n == 0);
		return s;
	endfunction

	// a read of rxdata pops the model, and an empty fifo reads as zero.
	function automatic logic [31:0] model_rx_read();
		if (rx_model.size() == 0)
			return 32'h0;
		return {24'h0, rx_model.pop_front()};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timed out while waiting for %s", what);
	endtask

	task automatic next_drive_slot();
		@(posedge clk);
		#1;  // inputs change 1 ns after the rising edge.
	endtask

	// drives one classic cycle and holds it until ack is seen at a falling edge.
	task automatic access_bus(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int n;
		rdat = '0;
		n    = 0;
		req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(negedge clk);
			n++;
		end while (!rsp.ack && n < ACK_LIMIT);
		if (rsp.ack) begin
			rdat = rsp.dat;  // read data is valid with ack.
			compare_value("ack latency", 32'd2, n);  // ack comes two clocks after the request.
		end else
			report_timeout("a wishbone ack");
		next_drive_slot();  // the side effect lands on this edge.
		req = '0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		access_bus(1'b1, adr, dat, unused);
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] dat);
		access_bus(1'b0, adr, 32'h0, dat);
	endtask

	task automatic set_divisor(input int d);
		write_reg(ADR_DIV, 32'(d));
		div_val = d;  // the decoder and driver time bits from this copy.
	endtask

	// samples txd at the middle of every bit of the next frame.
	task automatic receive_frame(output logic [7:0] data);
		int bit_clks, n;
		bit_clks = OVERSAMPLE * (div_val + 1);
		data     = '0;
		n        = 0;
		do begin
			@(negedge clk);
			n++;
		end while (txd && n < START_LIMIT);
		if (txd) begin
			report_timeout("a start bit on txd");
			return;
		end
		repeat (bit_clks / 2) @(negedge clk);
		compare_value("start bit", 32'h0, txd);
		for (int i = 0; i < 8; i++) begin
			repeat (bit_clks) @(negedge clk);
			data[i] = txd;  // least significant bit first.
		end
		repeat (bit_clks) @(negedge clk);
		compare_value("stop bit", 32'h1, txd);
	endtask

	task automatic send_frame(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};  // bit 0 is the start bit and goes out first.
		for (int i = 0; i < 10; i++) begin
			rxd_drv = frame[i];
			repeat (OVERSAMPLE * (div_val + 1)) @(posedge clk);
			#1;
		end
	endtask

	task automatic wait_rx_level(input int want);
		logic [31:0]  st;
		uart_status_t s;
		int           n;
		n = 0;
		do begin
			read_reg(ADR_STATUS, st);
			s = st;
			n++;
		end while (s.rx_level != 8'(want) && n < POLL_LIMIT);
		if (s.rx_level != 8'(want))
			report_timeout("the receive fifo level");
	endtask

	initial begin
		logic [31:0] rd;
		logic [7:0]  got;
		bit          ser_idle;
		int          n;
		seed     = 32'hf5a4_6001;
		errors   = 0;
		checks   = 0;
		timeouts = 0;
		div_val  = 0;
		req      = '0;
		rxd_drv  = 1'b1;  // the serial line idles high.
		loop_en  = 1'b0;
		n        = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!rst_n && n < 20);
		if (!rst_n)
			report_timeout("reset release");
		#1;

		// reset values of status, divisor and line.
		read_reg(ADR_STATUS, rd);
		compare_value("reset status", expected_status(0, 0), rd);
		read_reg(ADR_DIV, rd);
		compare_value("reset divisor", 32'h0, rd);
		compare_value("reset txd", 32'h1, txd);

		// four bytes at divisor 2 must come out in order with 24 clock bits.
		set_divisor(2);
		burst.delete();
		for (int i = 0; i < 4; i++)
			burst.push_back(rand_byte());
		fork
			for (int i = 0; i < 4; i++)
				write_reg(ADR_TXDATA, {24'h0, burst[i]});
			for (int i = 0; i < 4; i++) begin
				receive_frame(got);
				compare_value("transmit frame", burst[i], got);
			end
		join
		next_drive_slot();
		read_reg(ADR_STATUS, rd);
		compare_value("status after transmit", expected_status(0, 0), rd);

		// three frames arrive on rxd and one read more than that follows.
		for (int i = 0; i < 3; i++) begin
			got = rand_byte();
			rx_model.push_back(got);
			send_frame(got);
		end
		wait_rx_level(3);
		read_reg(ADR_STATUS, rd);
		compare_value("status with three received", expected_status(0, 3), rd);
		for (int i = 0; i < 4; i++) begin
			read_reg(ADR_RXDATA, rd);
			compare_value("receive data", model_rx_read(), rd);
		end
		read_reg(ADR_STATUS, rd);
		compare_value("status after draining", expected_status(0, rx_model.size()), rd);

		// overfill the transmit fifo while the first frame is on the line.
		burst.delete();
		written.delete();
		tx_model.delete();
		ser_idle = 1'b1;
		for (int i = 0; i < TX_DEPTH + 2; i++) begin
			got = rand_byte();
			written.push_back(got);
			if (ser_idle) begin
				burst.push_back(got);  // an idle serializer takes the first byte at once.
				ser_idle = 1'b0;
			end else if (tx_model.size() < TX_DEPTH) begin
				tx_model.push_back(got);
				burst.push_back(got);
			end
		end
		fork
			begin
				foreach (written[i])
					write_reg(ADR_TXDATA, {24'h0, written[i]});
				read_reg(ADR_STATUS, rd);
				compare_value("status when overfilled", expected_status(tx_model.size(), 0), rd);
			end
			for (int i = 0; i < burst.size(); i++) begin
				receive_frame(got);
				compare_value("overfill frame", burst[i], got);
			end
		join
		n = 0;
		for (int i = 0; i < 2 * OVERSAMPLE * (div_val + 1); i++) begin
			@(negedge clk);
			if (!txd)
				n = 1;  // a dropped byte must never reach the line.
		end
		compare_value("line idle after accepted bytes", 32'h0, n);
		next_drive_slot();
		read_reg(ADR_STATUS, rd);
		compare_value("status after overfill", expected_status(0, 0), rd);

		// loopback at full rate.
		loop_en = 1'b1;
		set_divisor(0);
		for (int i = 0; i < RX_DEPTH; i++) begin
			got = rand_byte();
			rx_model.push_back(got);
			write_reg(ADR_TXDATA, {24'h0, got});
		end
		wait_rx_level(RX_DEPTH);
		for (int i = 0; i < RX_DEPTH; i++) begin
			read_reg(ADR_RXDATA, rd);
			compare_value("loopback data", model_rx_read(), rd);
		end

		$display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// last line of defence when a wait loop itself misbehaves.
	initial begin
		#200_000;
		$display("simulation time limit reached before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tb_uart_assertions.sv
// concurrent checks on the bus handshake, the fifo flags and the idle line, bound into uart_top.
`timescale 1ns/1ps

module tb_uart_assertions (
	input logic                  clk,
	input logic                  rst_n,
	input uart_bus_pkg::wb_req_t wb_req,
	input uart_bus_pkg::wb_rsp_t wb_rsp,
	input logic                  txd,
	input logic                  tx_full,
	input logic                  tx_empty,
	input logic                  rx_full,
	input logic                  rx_empty
);

	// an acknowledge only ever answers a request that is still held.
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else $error("ack was raised without cyc and stb");

	// ack is a single-cycle pulse.
	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("ack stayed high for two cycles");

	tx_flags_ok: assert property (@(posedge clk) disable iff (!rst_n)
		!(tx_full && tx_empty))
		else $error("transmit fifo flagged full and empty together");

	rx_flags_ok: assert property (@(posedge clk) disable iff (!rst_n)
		!(rx_full && rx_empty))
		else $error("receive fifo flagged full and empty together");

	// right after reset the line idles high with no ack and empty fifos.
	idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (txd && !wb_rsp.ack && tx_empty && rx_empty))
		else $error("uart not idle when reset was released");

endmodule

bind uart_top tb_uart_assertions chk (
	.clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp), .txd(txd),
	.tx_full(tx_full), .tx_empty(tx_empty), .rx_full(rx_full), .rx_empty(rx_empty)
);

//--- tb_clk_gen.sv
// clock and reset source of the uart testbench, instantiated once by the top testbench module.
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD     = 8,  // clock period in ns.
	parameter int RST_CYCLES = 5   // rising edges seen with reset held low.
) (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;  // first rising edge at half a period.

	// reset is released 1 ns after an edge, like every other driven input.
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- uart_top.sv
// top level of the wishbone uart, joins the register block, fifos, baud generator and serializers.
`timescale 1ns/1ps

module uart_top #(
	parameter int TX_DEPTH = 4,  // power of two and not 1.
	parameter int RX_DEPTH = 4,  // power of two and not 1.
	localparam int TX_LW = $clog2(TX_DEPTH) + 1,
	localparam int RX_LW = $clog2(RX_DEPTH) + 1
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  uart_bus_pkg::wb_req_t wb_req,
	output uart_bus_pkg::wb_rsp_t wb_rsp,
	output logic                  txd,
	input  logic                  rxd
);

	import uart_regs_pkg::*;

	logic             tx_push, tx_pop, tx_full, tx_empty;
	logic [7:0]       tx_wdata, tx_rdata;
	logic [TX_LW-1:0] tx_level;
	logic             rx_push, rx_pop, rx_full, rx_empty;
	logic [7:0]       rx_wdata, rx_rdata;
	logic [RX_LW-1:0] rx_level;
	logic [DIV_W-1:0] div;
	logic             div_wr, os_tick;

	uart_regs #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) regs (
		.clk, .rst_n, .wb_req, .wb_rsp,
		.tx_full, .tx_level, .rx_empty, .rx_full, .rx_level, .rx_rdata,
		.tx_push, .tx_wdata, .rx_pop, .div, .div_wr
	);

	// bytes written by the bus wait here for the serializer.
	sync_fifo #(.DEPTH(TX_DEPTH), .WIDTH(8)) tx_fifo (
		.clk, .rst_n, .w_data(tx_wdata), .w_en(tx_push), .r_data(tx_rdata), .r_en(tx_pop),
		.full(tx_full), .empty(tx_empty), .level(tx_level)
	);

	// received bytes wait here until the bus reads them.
	sync_fifo #(.DEPTH(RX_DEPTH), .WIDTH(8)) rx_fifo (
		.clk, .rst_n, .w_data(rx_wdata), .w_en(rx_push), .r_data(rx_rdata), .r_en(rx_pop),
		.full(rx_full), .empty(rx_empty), .level(rx_level)
	);

	// one tick source keeps both directions at the same rate.
	uart_baud_gen baud (.clk, .rst_n, .div, .div_wr, .os_tick);

	uart_tx tx (
		.clk, .rst_n, .os_tick, .fifo_data(tx_rdata), .fifo_empty(tx_empty),
		.fifo_pop(tx_pop), .txd
	);

	uart_rx rx (
		.clk, .rst_n, .os_tick, .rxd, .fifo_full(rx_full),
		.fifo_push(rx_push), .fifo_data(rx_wdata)
	);

endmodule

//--- uart_regs.sv
// wishbone classic register block of the uart, decodes the register map and steers the fifos.
`timescale 1ns/1ps

module uart_regs #(
	parameter int TX_DEPTH = 4,
	parameter int RX_DEPTH = 4,
	localparam int TX_LW = $clog2(TX_DEPTH) + 1,  // width of the fifo level counts.
	localparam int RX_LW = $clog2(RX_DEPTH) + 1
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  uart_bus_pkg::wb_req_t           wb_req,
	output uart_bus_pkg::wb_rsp_t           wb_rsp,
	input  logic                            tx_full,
	input  logic [TX_LW-1:0]                tx_level,
	input  logic                            rx_empty,
	input  logic                            rx_full,
	input  logic [RX_LW-1:0]                rx_level,
	input  logic [7:0]                      rx_rdata,   // head of the receive fifo.
	output logic                            tx_push,
	output logic [7:0]                      tx_wdata,
	output logic                            rx_pop,
	output logic [uart_regs_pkg::DIV_W-1:0] div,
	output logic                            div_wr      // one pulse after a divisor write.
);

	import uart_bus_pkg::*;
	import uart_regs_pkg::*;

	logic             ack_q;   // the single acknowledge register.
	logic             wr_acc;  // write access in its ack cycle.
	logic             rd_acc;  // read access in its ack cycle.
	uart_status_t     status;
	logic [WB_DW-1:0] rdata;

	// ack rises one clock after the request is seen and never twice in a row,
	// so a request still held after its ack is not taken again.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) ack_q <= 1'b0;
		else        ack_q <= wb_req.cyc && wb_req.stb && !ack_q;
	end

	// every side effect happens in the ack cycle.
	assign wr_acc = ack_q && wb_req.cyc && wb_req.stb && wb_req.we;
	assign rd_acc = ack_q && wb_req.cyc && wb_req.stb && !wb_req.we;

	// pushes into a full fifo are dropped, pops from an empty one do nothing.
	assign tx_push  = wr_acc && (wb_req.adr == ADR_TXDATA) && !tx_full;
	assign tx_wdata = wb_req.dat[7:0];
	assign rx_pop   = rd_acc && (wb_req.adr == ADR_RXDATA) && !rx_empty;

	always_comb begin
		status          = '0;
		status.rx_level = 8'(rx_level);
		status.tx_level = 8'(tx_level);
		status.rx_full  = rx_full;
		status.rx_empty = rx_empty;
		status.tx_full  = tx_full;
		status.tx_empty = (tx_level == '0);  // the level alone tells empty.
	end

	// read data is built from the same fifo state that decides the pop.
	always_comb begin
		case (wb_req.adr)
			ADR_STATUS: rdata = WB_DW'(status);
			ADR_DIV:    rdata = WB_DW'(div);
			ADR_RXDATA: rdata = rx_empty ? '0 : WB_DW'(rx_rdata);  // empty reads zero.
			default:    rdata = '0;  // txdata is write only.
		endcase
	end

	always_comb begin
		wb_rsp.ack = ack_q;
		wb_rsp.dat = rd_acc ? rdata : '0;
	end

	// div_wr follows the register by one cycle, so the baud generator
	// reloads from the new value.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div    <= DIV_RESET;
			div_wr <= 1'b0;
		end else begin
			div_wr <= wr_acc && (wb_req.adr == ADR_DIV);
			if (wr_acc && (wb_req.adr == ADR_DIV))
				div <= wb_req.dat[DIV_W-1:0];
		end
	end

endmodule

//--- uart_rx.sv
// uart deserializer, oversamples rxd and pushes received 8n1 bytes into the receive fifo.
`timescale 1ns/1ps

module uart_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       os_tick,    // oversample strobe from the baud generator.
	input  logic       rxd,        // asynchronous serial input.
	input  logic       fifo_full,
	output logic       fifo_push,
	output logic [7:0] fifo_data
);

	import uart_regs_pkg::*;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t                       state;
	logic [1:0]                      sync_q;    // two-stage synchronizer.
	logic                            rxd_s;     // rxd in the clock domain.
	logic [$clog2(OVERSAMPLE)-1:0]   tick_cnt;  // ticks since the last sample point.
	logic [2:0]                      bit_cnt;   // data bit being received.
	logic [7:0]                      shreg;     // received bits enter at the top.
	logic                            mid_start;
	logic                            mid_bit;

	assign rxd_s = sync_q[1];

	// the start bit is checked half a bit after the falling edge was seen.
	assign mid_start = os_tick && (tick_cnt == OVERSAMPLE / 2 - 1);
	// later samples fall a whole bit apart, at each bit's middle.
	assign mid_bit   = os_tick && (tick_cnt == OVERSAMPLE - 1);

	// a byte is kept only with a high stop bit and room in the fifo.
	assign fifo_push = (state == RX_STOP) && mid_bit && rxd_s && !fifo_full;
	assign fifo_data = shreg;

	always_ff @(posedge clk) begin
		if (state == RX_DATA && mid_bit)
			shreg <= {rxd_s, shreg[7:1]};  // lsb arrives first.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q   <= 2'b11;  // the idle line is high.
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			sync_q <= {sync_q[0], rxd};
			if (os_tick) tick_cnt <= tick_cnt + 1'b1;
			case (state)
				RX_IDLE: if (os_tick && !rxd_s) begin
					state    <= RX_START;  // a low level may be a start bit.
					tick_cnt <= '0;
				end
				RX_START: if (mid_start) begin
					state    <= rxd_s ? RX_IDLE : RX_DATA;  // reject short glitches.
					tick_cnt <= '0;
					bit_cnt  <= '0;
				end
				RX_DATA: if (mid_bit) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) state <= RX_STOP;
				end
				RX_STOP: if (mid_bit) state <= RX_IDLE;  // hunt for the next start.
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

//--- uart_tx.sv
// uart serializer, pops bytes from the transmit fifo and sends 8n1 frames on txd.
`timescale 1ns/1ps

module uart_tx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       os_tick,     // oversample strobe from the baud generator.
	input  logic [7:0] fifo_data,   // head of the transmit fifo.
	input  logic       fifo_empty,
	output logic       fifo_pop,
	output logic       txd
);

	import uart_regs_pkg::*;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	tx_state_t                       state;
	logic [$clog2(OVERSAMPLE)-1:0]   tick_cnt;  // ticks spent in the current bit.
	logic [2:0]                      bit_cnt;   // data bit being sent.
	logic [7:0]                      shreg;     // byte being shifted out lsb first.
	logic                            bit_end;

	assign bit_end = os_tick && (tick_cnt == OVERSAMPLE - 1);

	// a byte leaves the fifo on a tick while idle, or right at the end of a
	// stop bit so that back-to-back frames have no gap.
	assign fifo_pop = !fifo_empty && ((state == TX_IDLE && os_tick) ||
		(state == TX_STOP && bit_end));

	// the line idles high and the stop bit is high too.
	assign txd = (state == TX_START) ? 1'b0 : (state == TX_DATA) ? shreg[0] : 1'b1;

	always_ff @(posedge clk) begin
		if (fifo_pop)
			shreg <= fifo_data;              // load the next frame.
		else if (state == TX_DATA && bit_end)
			shreg <= {1'b0, shreg[7:1]};     // move to the next bit.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			if (os_tick) tick_cnt <= tick_cnt + 1'b1;  // wraps after eight ticks.
			if (fifo_pop) begin
				state    <= TX_START;
				tick_cnt <= '0;  // the pop tick is the first of the start bit.
			end else if (bit_end) begin
				case (state)
					TX_START: begin
						state   <= TX_DATA;
						bit_cnt <= '0;
					end
					TX_DATA: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) state <= TX_STOP;
					end
					TX_STOP: state <= TX_IDLE;  // nothing queued behind this frame.
					default: state <= TX_IDLE;
				endcase
			end
		end
	end

endmodule

//--- uart_baud_gen.sv
// oversample tick generator for the uart, one pulse every divisor plus one clocks.
`timescale 1ns/1ps

module uart_baud_gen (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [uart_regs_pkg::DIV_W-1:0] div,     // current divisor value.
	input  logic                         div_wr,  // divisor was just rewritten.
	output logic                         os_tick  // one-cycle oversample strobe.
);

	import uart_regs_pkg::*;

	logic [DIV_W-1:0] cnt;  // clocks left until the next tick.

	// the counter runs down to zero and then reloads from the divisor.
	// with a divisor of zero it stays at zero and ticks every clock.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= DIV_RESET;
			os_tick <= 1'b0;
		end else if (div_wr) begin
			cnt     <= div;   // a new rate starts counting at once.
			os_tick <= 1'b0;  // no tick from the old count.
		end else if (cnt == '0) begin
			cnt     <= div;
			os_tick <= 1'b1;
		end else begin
			cnt     <= cnt - 1'b1;
			os_tick <= 1'b0;
		end
	end

	// both serializers count these ticks, so the bit period is
	// oversample times divisor plus one clocks.

endmodule

//--- sync_fifo.sv
// synchronous register-array fifo with registered flags, used for the uart transmit and receive paths.
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 4,  // must be a power of two and not 1.
	parameter int WIDTH = 8,
	localparam int W_ADDR = $clog2(DEPTH)
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [WIDTH-1:0]  w_data,
	input  logic              w_en,    // only asserted while full is low.
	output logic [WIDTH-1:0]  r_data,
	input  logic              r_en,    // only asserted while empty is low.
	output logic              full,
	output logic              empty,
	output logic [W_ADDR:0]   level
);

	logic [WIDTH-1:0]  mem [DEPTH];
	logic [W_ADDR-1:0] w_ptr;
	logic [W_ADDR-1:0] r_ptr;

	// the oldest entry is always visible, so a read needs no extra cycle.
	assign r_data = mem[r_ptr];

	// each push writes the entry at the write pointer.
	always_ff @(posedge clk) begin
		if (w_en)
			mem[w_ptr] <= w_data;
	end

	// pointers wrap naturally because the depth is a power of two.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_ptr <= '0;
			r_ptr <= '0;
			level <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (w_en) w_ptr <= w_ptr + 1'b1;
			if (r_en) r_ptr <= r_ptr + 1'b1;
			if (w_en && !r_en) begin
				level <= level + 1'b1;  // a push alone grows the count.
				empty <= 1'b0;
				full  <= (level == (W_ADDR+1)'(DEPTH - 1));
			end else if (r_en && !w_en) begin
				level <= level - 1'b1;  // a pop alone shrinks the count.
				full  <= 1'b0;
				empty <= (level == (W_ADDR+1)'(1));
			end
			// a push and a pop together leave the count and flags alone.
		end
	end

endmodule

//--- uart_regs_pkg.sv
// register map, status layout and serial timing constants of the uart.
package uart_regs_pkg;

	// word indices of the four registers.
	localparam logic [1:0] ADR_STATUS = 2'd0;  // read only flags and levels.
	localparam logic [1:0] ADR_DIV    = 2'd1;  // baud divisor that reads back as written.
	localparam logic [1:0] ADR_TXDATA = 2'd2;  // write pushes one byte.
	localparam logic [1:0] ADR_RXDATA = 2'd3;  // read pops one byte.

	// the divisor is sixteen bits wide.
	localparam int DIV_W = 16;

	// after reset the oversample tick runs at the full clock rate.
	localparam logic [DIV_W-1:0] DIV_RESET = '0;

	// number of oversample ticks in one bit period.
	localparam int OVERSAMPLE = 8;

	// layout of the status word.
	// levels are zero extended from the fifo counters.
	typedef struct packed {
		logic [7:0] rsvd_hi;   // reads as zero.
		logic [7:0] rx_level;  // bytes waiting in the receive fifo.
		logic [7:0] tx_level;  // bytes waiting in the transmit fifo.
		logic [3:0] rsvd_lo;   // reads as zero.
		logic       rx_full;
		logic       rx_empty;
		logic       tx_full;
		logic       tx_empty;
	} uart_status_t;

	// the status word is read only.
	// writes to it are acknowledged and have no effect.

endpackage

//--- uart_bus_pkg.sv
// wishbone classic types shared by the register block, the top level and the testbench.
package uart_bus_pkg;

	// the data bus is a full word wide.
	localparam int WB_DW = 32;

	// the address is a word index into the four-word register map.
	localparam int WB_AW = 2;

	// master to slave request.
	// the master holds all fields stable until it samples ack.
	typedef struct packed {
		logic             cyc;  // bus cycle in progress.
		logic             stb;  // this slave is selected.
		logic             we;   // high for a write, low for a read.
		logic [WB_AW-1:0] adr;  // a word index rather than a byte address.
		logic [WB_DW-1:0] dat;  // write data that reads ignore.
	} wb_req_t;

	// slave to master response.
	typedef struct packed {
		logic             ack;  // one-cycle acknowledge.
		logic [WB_DW-1:0] dat;  // read data that is valid only with ack.
	} wb_rsp_t;

	// all accesses are whole words, so there is no select field.
	// reads of unused bits return zero.

	// the bus has no error or retry response.
	// every access ends with a plain ack.

endpackage
